/* hw/fheep_pad_pkg.sv */
// Default sizes and the function-select encoding of the pad-mux subsystem, shared by all its blocks
`default_nettype none

package fheep_pad_pkg;

  // Shared pads in order: spi2 cs0, cs1, sck, sd0..sd3, then i2c scl and sda
  localparam int unsigned NUM_MUX_PAD = 9;

  // Width of one pad's function-select field
  localparam int unsigned MUX_SEL_W = 4;

  // Register bus, byte addressed with one 32-bit word per pad
  localparam int unsigned REG_ADDR_W = 8;
  localparam int unsigned REG_DATA_W = 32;

  localparam int unsigned RST_SYNC_STAGES = 2;

  // Codes not listed here route the pad like PAD_FUNC_PRIMARY
  typedef enum logic [MUX_SEL_W-1:0] {
    PAD_FUNC_PRIMARY = MUX_SEL_W'(0),
    PAD_FUNC_GPIO    = MUX_SEL_W'(1)
  } pad_func_e;

endpackage

`default_nettype wire

/* hw/rst_sync.sv */
// Reset synchronizer; asserts the system reset with the external one and releases it after a fixed delay
`timescale 1ns/100ps
`default_nettype none

module rst_sync #(
  parameter int unsigned RST_SYNC_STAGES = fheep_pad_pkg::RST_SYNC_STAGES
) (
  input  logic clk_i,
  input  logic rst_n_i,
  output logic rst_n_o
);

  logic [RST_SYNC_STAGES-1:0] sync_q;

  // Ones shift in from the bottom once the external reset is gone
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= RST_SYNC_STAGES'({sync_q, 1'b1});
    end
  end

  assign rst_n_o = sync_q[RST_SYNC_STAGES-1];

  // System reset must follow the external reset within one edge
  a_rst_follows : assert property (
    @(posedge clk_i) !rst_n_i |=> !rst_n_o
  ) else $error("system reset still high after external reset was sampled low");

endmodule

`default_nettype wire

/* hw/pad_ctrl_regs.sv */
// Function-select register bank, one word per shared pad on a simple valid-strobe register bus
`timescale 1ns/100ps
`default_nettype none

module pad_ctrl_regs #(
  parameter int unsigned NUM_MUX_PAD = fheep_pad_pkg::NUM_MUX_PAD,
  parameter int unsigned MUX_SEL_W   = fheep_pad_pkg::MUX_SEL_W,
  parameter int unsigned REG_ADDR_W  = fheep_pad_pkg::REG_ADDR_W,
  parameter int unsigned REG_DATA_W  = fheep_pad_pkg::REG_DATA_W
) (
  input  logic                                       clk_i,
  input  logic                                       rst_n_i,

  input  logic                                       reg_valid_i,
  input  logic                                       reg_write_i,
  input  logic [REG_ADDR_W-1:0]                      reg_addr_i,
  input  logic [REG_DATA_W-1:0]                      reg_wdata_i,
  output logic [REG_DATA_W-1:0]                      reg_rdata_o,
  output logic                                       reg_error_o,

  output fheep_pad_pkg::pad_func_e [NUM_MUX_PAD-1:0] pad_sel_o
);

  localparam int unsigned IDX_W = REG_ADDR_W - 2;

  fheep_pad_pkg::pad_func_e [NUM_MUX_PAD-1:0] sel_q;

  logic [IDX_W-1:0] word_idx;
  logic             addr_ok;
  logic             wr_en;
  logic             rd_en;

  // Byte address 4k selects pad k
  assign word_idx = reg_addr_i[REG_ADDR_W-1:2];
  assign addr_ok  = (reg_addr_i[1:0] == 2'b00) && (word_idx < IDX_W'(NUM_MUX_PAD));

  assign wr_en       = reg_valid_i && reg_write_i && addr_ok;
  assign rd_en       = reg_valid_i && !reg_write_i && addr_ok;
  assign reg_error_o = reg_valid_i && !addr_ok;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_MUX_PAD; i++) begin
        sel_q[i] <= fheep_pad_pkg::PAD_FUNC_PRIMARY;
      end
    end else if (wr_en) begin
      // Only the select field is kept, upper data bits are dropped
      sel_q[word_idx] <= fheep_pad_pkg::pad_func_e'(reg_wdata_i[MUX_SEL_W-1:0]);
    end
  end

  // Zero-latency read, zero-extended
  always_comb begin
    reg_rdata_o = '0;
    if (rd_en) begin
      reg_rdata_o[MUX_SEL_W-1:0] = sel_q[word_idx];
    end
  end

  assign pad_sel_o = sel_q;

  a_err_needs_valid : assert property (
    @(posedge clk_i) reg_error_o |-> reg_valid_i
  ) else $error("bus error raised without an access");

  // A rejected access never leaks register contents
  a_err_reads_zero : assert property (
    @(posedge clk_i) reg_error_o |-> (reg_rdata_o == '0)
  ) else $error("read data not zero on a bus error");

endmodule

`default_nettype wire

/* hw/pad_func_mux.sv */
// Per-pad routing of output value, output enable and input value between peripheral and spare GPIO
`timescale 1ns/100ps
`default_nettype none

module pad_func_mux #(
  parameter int unsigned NUM_MUX_PAD = fheep_pad_pkg::NUM_MUX_PAD,
  parameter int unsigned MUX_SEL_W   = fheep_pad_pkg::MUX_SEL_W
) (
  input  fheep_pad_pkg::pad_func_e [NUM_MUX_PAD-1:0] pad_sel_i,

  input  logic [NUM_MUX_PAD-1:0]                     periph_out_i,
  input  logic [NUM_MUX_PAD-1:0]                     periph_oe_i,
  input  logic [NUM_MUX_PAD-1:0]                     gpio_out_i,
  input  logic [NUM_MUX_PAD-1:0]                     gpio_oe_i,
  input  logic [NUM_MUX_PAD-1:0]                     pad_in_i,

  output logic [NUM_MUX_PAD-1:0]                     pad_out_o,
  output logic [NUM_MUX_PAD-1:0]                     pad_oe_o,
  output logic [NUM_MUX_PAD-1:0]                     periph_in_o,
  output logic [NUM_MUX_PAD-1:0]                     gpio_in_o
);

  // Field width has to agree with the select encoding
  if (MUX_SEL_W != $bits(fheep_pad_pkg::pad_func_e)) begin : g_sel_w_check
    $error("MUX_SEL_W does not match the width of pad_func_e");
  end

  always_comb begin
    for (int i = 0; i < NUM_MUX_PAD; i++) begin
      // Unselected side reads a quiet zero
      periph_in_o[i] = 1'b0;
      gpio_in_o[i]   = 1'b0;
      case (pad_sel_i[i])
        fheep_pad_pkg::PAD_FUNC_GPIO: begin
          pad_out_o[i] = gpio_out_i[i];
          pad_oe_o[i]  = gpio_oe_i[i];
          gpio_in_o[i] = pad_in_i[i];
        end
        // Primary, and any unsupported code
        default: begin
          pad_out_o[i]   = periph_out_i[i];
          pad_oe_o[i]    = periph_oe_i[i];
          periph_in_o[i] = pad_in_i[i];
        end
      endcase
    end
  end

  // A pad input reaches at most one consumer
  always_comb begin
    a_in_one_side : assert ((periph_in_o & gpio_in_o) == '0)
      else $error("pad input routed to both peripheral and GPIO");
  end

endmodule

`default_nettype wire

/* hw/fheep_pad_top.sv */
// Pad-mux subsystem top; ties reset synchronizer, select registers and pad function mux together
`timescale 1ns/100ps
`default_nettype none

module fheep_pad_top #(
  parameter int unsigned NUM_MUX_PAD     = fheep_pad_pkg::NUM_MUX_PAD,
  parameter int unsigned MUX_SEL_W       = fheep_pad_pkg::MUX_SEL_W,
  parameter int unsigned REG_ADDR_W      = fheep_pad_pkg::REG_ADDR_W,
  parameter int unsigned REG_DATA_W      = fheep_pad_pkg::REG_DATA_W,
  parameter int unsigned RST_SYNC_STAGES = fheep_pad_pkg::RST_SYNC_STAGES
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  output logic                   sys_rst_n_o,

  // Register bus
  input  logic                   reg_valid_i,
  input  logic                   reg_write_i,
  input  logic [REG_ADDR_W-1:0]  reg_addr_i,
  input  logic [REG_DATA_W-1:0]  reg_wdata_i,
  output logic [REG_DATA_W-1:0]  reg_rdata_o,
  output logic                   reg_error_o,

  // Pad side
  input  logic [NUM_MUX_PAD-1:0] periph_out_i,
  input  logic [NUM_MUX_PAD-1:0] periph_oe_i,
  input  logic [NUM_MUX_PAD-1:0] gpio_out_i,
  input  logic [NUM_MUX_PAD-1:0] gpio_oe_i,
  input  logic [NUM_MUX_PAD-1:0] pad_in_i,
  output logic [NUM_MUX_PAD-1:0] pad_out_o,
  output logic [NUM_MUX_PAD-1:0] pad_oe_o,
  output logic [NUM_MUX_PAD-1:0] periph_in_o,
  output logic [NUM_MUX_PAD-1:0] gpio_in_o
);

  logic                                       sys_rst_n;
  fheep_pad_pkg::pad_func_e [NUM_MUX_PAD-1:0] pad_sel;

  rst_sync #(
    .RST_SYNC_STAGES(RST_SYNC_STAGES)
  ) u_rst_sync (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rst_n_o(sys_rst_n)
  );

  // Rest of the chip runs on the same synchronized reset
  assign sys_rst_n_o = sys_rst_n;

  pad_ctrl_regs #(
    .NUM_MUX_PAD(NUM_MUX_PAD),
    .MUX_SEL_W  (MUX_SEL_W),
    .REG_ADDR_W (REG_ADDR_W),
    .REG_DATA_W (REG_DATA_W)
  ) u_pad_ctrl_regs (
    .clk_i      (clk_i),
    .rst_n_i    (sys_rst_n),
    .reg_valid_i(reg_valid_i),
    .reg_write_i(reg_write_i),
    .reg_addr_i (reg_addr_i),
    .reg_wdata_i(reg_wdata_i),
    .reg_rdata_o(reg_rdata_o),
    .reg_error_o(reg_error_o),
    .pad_sel_o  (pad_sel)
  );

  pad_func_mux #(
    .NUM_MUX_PAD(NUM_MUX_PAD),
    .MUX_SEL_W  (MUX_SEL_W)
  ) u_pad_func_mux (
    .pad_sel_i   (pad_sel),
    .periph_out_i(periph_out_i),
    .periph_oe_i (periph_oe_i),
    .gpio_out_i  (gpio_out_i),
    .gpio_oe_i   (gpio_oe_i),
    .pad_in_i    (pad_in_i),
    .pad_out_o   (pad_out_o),
    .pad_oe_o    (pad_oe_o),
    .periph_in_o (periph_in_o),
    .gpio_in_o   (gpio_in_o)
  );

endmodule

`default_nettype wire

/* dv/tb_fheep_pad_top.sv */
// Self-checking testbench for the pad-mux subsystem; build with src.f, top module tb_fheep_pad_top
`timescale 1ns/100ps
`default_nettype none

module tb_fheep_pad_top;

  localparam int unsigned NUM_MUX_PAD     = fheep_pad_pkg::NUM_MUX_PAD;
  localparam int unsigned MUX_SEL_W       = fheep_pad_pkg::MUX_SEL_W;
  localparam int unsigned REG_ADDR_W      = fheep_pad_pkg::REG_ADDR_W;
  localparam int unsigned REG_DATA_W      = fheep_pad_pkg::REG_DATA_W;
  localparam int unsigned RST_SYNC_STAGES = fheep_pad_pkg::RST_SYNC_STAGES;

  localparam int unsigned CLK_PERIOD      = 20;
  localparam int unsigned RESET_CYCLES    = 3;
  localparam int unsigned TEST_CYCLES     = 120;
  localparam int unsigned MARGIN_CYCLES   = 40;
  localparam int unsigned NUM_RAND_WRITES = 12;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   sys_rst_n;
  logic                   reg_valid;
  logic                   reg_write;
  logic [REG_ADDR_W-1:0]  reg_addr;
  logic [REG_DATA_W-1:0]  reg_wdata;
  logic [REG_DATA_W-1:0]  reg_rdata;
  logic                   reg_error;
  logic [NUM_MUX_PAD-1:0] periph_out;
  logic [NUM_MUX_PAD-1:0] periph_oe;
  logic [NUM_MUX_PAD-1:0] gpio_out;
  logic [NUM_MUX_PAD-1:0] gpio_oe;
  logic [NUM_MUX_PAD-1:0] pad_in;
  logic [NUM_MUX_PAD-1:0] pad_out;
  logic [NUM_MUX_PAD-1:0] pad_oe;
  logic [NUM_MUX_PAD-1:0] periph_in;
  logic [NUM_MUX_PAD-1:0] gpio_in;

  logic [15:0] lfsr_state = 16'd48;
  int          errors = 0;
  int          cycle_cnt = 0;
  logic        chk_en;

  // Reference model state
  int                                     rst_cnt = 0;
  logic                                   exp_rst = 1'b0;
  logic [NUM_MUX_PAD-1:0][MUX_SEL_W-1:0]  model_sel;
  int                                     exp_idx;
  logic                                   exp_ok;
  logic [REG_DATA_W-1:0]                  exp_rdata;

  fheep_pad_top #(
    .NUM_MUX_PAD    (NUM_MUX_PAD),
    .MUX_SEL_W      (MUX_SEL_W),
    .REG_ADDR_W     (REG_ADDR_W),
    .REG_DATA_W     (REG_DATA_W),
    .RST_SYNC_STAGES(RST_SYNC_STAGES)
  ) u_fheep_pad_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .sys_rst_n_o (sys_rst_n),
    .reg_valid_i (reg_valid),
    .reg_write_i (reg_write),
    .reg_addr_i  (reg_addr),
    .reg_wdata_i (reg_wdata),
    .reg_rdata_o (reg_rdata),
    .reg_error_o (reg_error),
    .periph_out_i(periph_out),
    .periph_oe_i (periph_oe),
    .gpio_out_i  (gpio_out),
    .gpio_oe_i   (gpio_oe),
    .pad_in_i    (pad_in),
    .pad_out_o   (pad_out),
    .pad_oe_o    (pad_oe),
    .periph_in_o (periph_in),
    .gpio_in_o   (gpio_in)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic take_bit();
    lfsr_state = lfsr_step(lfsr_state);
    return lfsr_state[0];
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], take_bit()};
    end
    return r;
  endfunction

  task automatic report_fail(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic drive_pads();
    for (int i = 0; i < NUM_MUX_PAD; i++) begin
      periph_out[i] = take_bit();
      periph_oe[i]  = take_bit();
      gpio_out[i]   = take_bit();
      gpio_oe[i]    = take_bit();
      pad_in[i]     = take_bit();
    end
  endtask

  task automatic bus_access(input logic wr, input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = wr;
    reg_addr  = addr;
    reg_wdata = data;
    drive_pads();
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      reg_valid = 1'b0;
      reg_write = 1'b0;
      drive_pads();
    end
  endtask

  task automatic read_all_pads();
    for (int k = 0; k < NUM_MUX_PAD; k++) begin
      bus_access(1'b0, REG_ADDR_W'(4 * k), '0);
    end
  endtask

  assign chk_en = (cycle_cnt >= 2);

  // Release comes RST_SYNC_STAGES edges after rst_n is first seen high
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (!rst_n) begin
      rst_cnt <= 0;
      exp_rst <= 1'b0;
    end else if (rst_cnt < RST_SYNC_STAGES) begin
      rst_cnt <= rst_cnt + 1;
      exp_rst <= (rst_cnt + 1 >= RST_SYNC_STAGES);
    end
  end

  always_comb begin
    exp_idx   = int'(reg_addr[REG_ADDR_W-1:2]);
    exp_ok    = (reg_addr[1:0] == 2'b00) && (exp_idx < NUM_MUX_PAD);
    exp_rdata = '0;
    if (reg_valid && !reg_write && exp_ok) begin
      exp_rdata[MUX_SEL_W-1:0] = model_sel[exp_idx];
    end
  end

  always @(posedge clk) begin
    if (!exp_rst) begin
      model_sel <= '0;
    end else if (reg_valid && reg_write && exp_ok) begin
      model_sel[exp_idx] <= reg_wdata[MUX_SEL_W-1:0];
    end
  end

  a_sys_rst : assert property (@(posedge clk) chk_en |-> (sys_rst_n == exp_rst))
    else report_fail($sformatf("sys_rst_n_o is %b, expected %b",
                               $sampled(sys_rst_n), $sampled(exp_rst)));

  a_bus_error : assert property (@(posedge clk)
    chk_en |-> (reg_error == (reg_valid && !exp_ok)))
    else report_fail($sformatf("reg_error_o is %b at address 0x%0h",
                               $sampled(reg_error), $sampled(reg_addr)));

  a_bus_rdata : assert property (@(posedge clk) chk_en |-> (reg_rdata == exp_rdata))
    else report_fail($sformatf("reg_rdata_o is 0x%0h, expected 0x%0h",
                               $sampled(reg_rdata), $sampled(exp_rdata)));

  for (genvar k = 0; k < NUM_MUX_PAD; k++) begin : g_route_chk
    a_primary : assert property (@(posedge clk)
      chk_en && (model_sel[k] != fheep_pad_pkg::PAD_FUNC_GPIO) |->
        (pad_out[k] == periph_out[k]) && (pad_oe[k] == periph_oe[k]) &&
        (periph_in[k] == pad_in[k]) && !gpio_in[k])
      else report_fail($sformatf("pad %0d not routed to its peripheral", k));

    a_gpio : assert property (@(posedge clk)
      chk_en && (model_sel[k] == fheep_pad_pkg::PAD_FUNC_GPIO) |->
        (pad_out[k] == gpio_out[k]) && (pad_oe[k] == gpio_oe[k]) &&
        (gpio_in[k] == pad_in[k]) && !periph_in[k])
      else report_fail($sformatf("pad %0d not routed to its GPIO", k));
  end

  initial begin
    #((RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Watchdog expired before the test sequence finished");
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int                    k;
    logic [REG_DATA_W-1:0] data;
    logic [MUX_SEL_W-1:0]  sel;

    rst_n      = 1'b0;
    reg_valid  = 1'b0;
    reg_write  = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    periph_out = '0;
    periph_oe  = '0;
    gpio_out   = '0;
    gpio_oe    = '0;
    pad_in     = '0;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    while (sys_rst_n !== 1'b1) begin
      @(negedge clk);
    end

    read_all_pads();
    idle_cycles(10);

    // Random selects, half of them GPIO, junk in the upper data bits
    for (int n = 0; n < NUM_RAND_WRITES; n++) begin
      k    = int'(take_bits(4) % NUM_MUX_PAD);
      data = REG_DATA_W'(take_bits(REG_DATA_W));
      if (take_bit()) begin
        sel = MUX_SEL_W'(1);
      end else begin
        sel = MUX_SEL_W'(take_bits(MUX_SEL_W));
      end
      data[MUX_SEL_W-1:0] = sel;
      bus_access(1'b1, REG_ADDR_W'(4 * k), data);
      bus_access(1'b0, REG_ADDR_W'(4 * k), '0);
      idle_cycles(1);
    end

    // Unsupported code on pad 3, GPIO on pad 0
    bus_access(1'b1, REG_ADDR_W'(12), REG_DATA_W'(32'hA5A5_0005));
    bus_access(1'b0, REG_ADDR_W'(12), '0);
    bus_access(1'b1, REG_ADDR_W'(0), REG_DATA_W'(32'hFFFF_FFF1));
    bus_access(1'b0, REG_ADDR_W'(0), '0);
    idle_cycles(2);

    bus_access(1'b0, REG_ADDR_W'(4 * NUM_MUX_PAD), '0);
    bus_access(1'b1, REG_ADDR_W'(4 * NUM_MUX_PAD), REG_DATA_W'(1));
    bus_access(1'b1, REG_ADDR_W'(252), REG_DATA_W'(1));
    bus_access(1'b1, REG_ADDR_W'(13), REG_DATA_W'(1));
    bus_access(1'b0, REG_ADDR_W'(2), '0);
    bus_access(1'b1, REG_ADDR_W'(1), REG_DATA_W'(5));
    read_all_pads();
    idle_cycles(3);

    $display("tb_fheep_pad_top finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/fheep_pad_pkg.sv
hw/rst_sync.sv
hw/pad_ctrl_regs.sv
hw/pad_func_mux.sv
hw/fheep_pad_top.sv
dv/tb_fheep_pad_top.sv

/* Makefile */
# Verilator flow for the pad-mux subsystem

VERILATOR  ?= verilator
TOP        ?= tb_fheep_pad_top
RTL_TOP    ?= fheep_pad_top
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation completed successfully
VFLAGS     ?= --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

SRCS      := $(shell cat $(FILELIST))
RTL_FILES ?= $(filter hw/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Pass message not found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
